//--- sources.f
+incdir+.
renamePkg.sv
TagBuffer.sv
RegAliasTable.sv
RenameControl.sv
RecoveryCounter.sv
Rename.sv
RenameTb.sv

//--- renameTbTable.svh
`ifndef RENAME_TB_TABLE_SVH
`define RENAME_TB_TABLE_SVH

// Columns: repeat count, rename slot 0, rename slot 1, commit slot 0, commit slot 1,
// mispr, misprSqN, expected stall
// makeReq(valid, archSrcA, archSrcB, archDst), makeCommit(valid, archDst, tagDst)

// Identity sources after reset, tags 63 and 62, bypass of r3 into slot 1
addRow(1, makeReq(1, 1, 2, 3), makeReq(1, 3, 4, 5), idleCommit, idleCommit, 0, 0, 0);
// Slot 1 alone gets the second highest free tag, commits free tags 3 and 5
addRow(1, idleReq, makeReq(1, 3, 5, 6),
       makeCommit(1, 3, 63), makeCommit(1, 5, 62), 0, 0, 0);
// Both sources of slot 1 bypassed
addRow(1, makeReq(1, 3, 6, 7), makeReq(1, 7, 7, 7), makeCommit(1, 6, 60), idleCommit, 0, 0, 0);
// Same destination twice in one commit group
addRow(1, idleReq, idleReq, makeCommit(1, 7, 61), makeCommit(1, 7, 59), 0, 0, 0);
// Freed tag 61 comes back as the highest free tag
addRow(1, makeReq(1, 0, 0, 8), makeReq(1, 0, 0, 9), idleCommit, idleCommit, 0, 0, 0);
// Drain the free pool
addRow(15, makeReq(1, 8, 9, 10), makeReq(1, 9, 8, 11), idleCommit, idleCommit, 0, 0, 0);
addRow(3, makeReq(1, 1, 2, 12), makeReq(1, 2, 1, 13), idleCommit, idleCommit, 0, 0, 1);
addRow(1, makeReq(1, 1, 2, 12), makeReq(1, 2, 1, 13), makeCommit(1, 8, 61), idleCommit,
       0, 0, 1);
// One free tag is enough for a single request
addRow(1, makeReq(1, 10, 11, 12), idleReq, idleCommit, idleCommit, 0, 0, 0);
// Misprediction after sqN 5, then 32 stalled cycles
addRow(1, idleReq, idleReq, idleCommit, idleCommit, 1, 5, 0);
addRow(32, makeReq(1, 1, 2, 3), makeReq(1, 4, 5, 6), idleCommit, idleCommit, 0, 0, 1);
// Restored map and sqN 6
addRow(1, makeReq(1, 8, 9, 10), makeReq(1, 10, 3, 11), idleCommit, idleCommit, 0, 0, 0);
addRow(1, idleReq, idleReq, makeCommit(1, 10, 58), makeCommit(1, 11, 57), 0, 0, 0);
addRow(1, idleReq, idleReq, idleCommit, idleCommit, 0, 0, 0);
// Second misprediction moves sqN to the wrap point
addRow(1, idleReq, idleReq, idleCommit, idleCommit, 1, 62, 0);
addRow(32, idleReq, idleReq, idleCommit, idleCommit, 0, 0, 1);
addRow(1, makeReq(1, 10, 11, 12), makeReq(1, 12, 0, 13), idleCommit, idleCommit, 0, 0, 0);
addRow(2, idleReq, idleReq, idleCommit, idleCommit, 0, 0, 0);

`endif

//--- RenameTb.sv
`timescale 1ns/100ps
`include "rename_config.svh"

module RenameTb import renamePkg::*; ();

    typedef struct packed {
        logic [7:0] count;
        RenameReq ren0;
        RenameReq ren1;
        CommitReq com0;
        CommitReq com1;
        logic mispr;
        logic [`SQN_W-1:0] misprSqN;
        logic expStall;
    } TbRow;

    localparam RenameReq idleReq = '0;
    localparam CommitReq idleCommit = '0;

    logic clk;
    logic rst;
    RenameReq renameIn [`NUM_UOPS];
    CommitReq commitIn [`NUM_UOPS];
    logic mispr;
    logic [`SQN_W-1:0] misprSqN;
    RenameResult renameOut [`NUM_UOPS];
    logic stall;

    TbRow rows [$];
    int mismatches = 0;
    int tableErrors = 0;
    int cycles = 0;
    int limit = 1000;

    // Reference state
    bit used [`NUM_TAGS];
    bit committed [`NUM_TAGS];
    logic [`SQN_W-1:0] tagSqN [`NUM_TAGS];
    logic [`TAG_W-1:0] specMap [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0] commMap [`NUM_ARCH_REGS];
    logic [`SQN_W-1:0] seqBase;
    int recLeft;
    int recIdx;
    RenameResult expOut [`NUM_UOPS];

    Rename DUT (
        .clk(clk),
        .rst(rst),
        .renameIn(renameIn),
        .commitIn(commitIn),
        .mispr(mispr),
        .misprSqN(misprSqN),
        .renameOut(renameOut),
        .stall(stall)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

    function automatic RenameReq makeReq(input logic v, input int a, input int b, input int d);
        RenameReq r;
        r.valid = v;
        r.archSrcA = a[`ARCH_W-1:0];
        r.archSrcB = b[`ARCH_W-1:0];
        r.archDst = d[`ARCH_W-1:0];
        return r;
    endfunction

    function automatic CommitReq makeCommit(input logic v, input int d, input int t);
        CommitReq c;
        c.valid = v;
        c.archDst = d[`ARCH_W-1:0];
        c.tagDst = t[`TAG_W-1:0];
        return c;
    endfunction

    task automatic addRow(input int count, input RenameReq r0, input RenameReq r1,
                          input CommitReq c0, input CommitReq c1, input logic mis,
                          input int misSqN, input logic expStall);
        TbRow row;
        row.count = count[7:0];
        row.ren0 = r0;
        row.ren1 = r1;
        row.com0 = c0;
        row.com1 = c1;
        row.mispr = mis;
        row.misprSqN = misSqN[`SQN_W-1:0];
        row.expStall = expStall;
        rows.push_back(row);
    endtask

    task automatic loadTable();
        `include "renameTbTable.svh"
    endtask

    task automatic checkField(input string what, input int slot, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0d ns: slot %0d %s is %0d, expected %0d",
                     $time, slot, what, got, exp);
        end
    endtask

    task automatic checkOutputs();
        for (int i = 0; i < `NUM_UOPS; i++) begin
            checkField("valid", i, renameOut[i].valid, expOut[i].valid);
            if (expOut[i].valid && renameOut[i].valid) begin
                checkField("sqN", i, renameOut[i].sqN, expOut[i].sqN);
                checkField("tagSrcA", i, renameOut[i].tagSrcA, expOut[i].tagSrcA);
                checkField("tagSrcB", i, renameOut[i].tagSrcB, expOut[i].tagSrcB);
                checkField("tagDst", i, renameOut[i].tagDst, expOut[i].tagDst);
            end
        end
    endtask

    task automatic driveRow(input TbRow row);
        renameIn[0] = row.ren0;
        renameIn[1] = row.ren1;
        commitIn[0] = row.com0;
        commitIn[1] = row.com1;
        mispr = row.mispr;
        misprSqN = row.misprSqN;
    endtask

    // Checks stall for the current cycle, then advances the model over the next edge
    task automatic stepModel(input TbRow row);
        RenameReq req [`NUM_UOPS];
        CommitReq com [`NUM_UOPS];
        logic [`TAG_W-1:0] freeTag [`NUM_UOPS];
        logic [`TAG_W-1:0] oldComm [`NUM_ARCH_REGS];
        logic [`SQN_W-1:0] seq;
        logic [`SQN_W-1:0] age;
        logic [`TAG_W-1:0] prevTag;
        int freeCnt;
        int nValid;
        bit expStall;
        bit issue;
        bit newest;
        req[0] = row.ren0;
        req[1] = row.ren1;
        com[0] = row.com0;
        com[1] = row.com1;
        freeCnt = 0;
        freeTag[0] = '0;
        freeTag[1] = '0;
        for (int t = `NUM_TAGS - 1; t >= 0; t--) begin
            if (!used[t]) begin
                if (freeCnt < `NUM_UOPS) freeTag[freeCnt] = t[`TAG_W-1:0];
                freeCnt++;
            end
        end
        nValid = req[0].valid + req[1].valid;
        expStall = recLeft > 0 || freeCnt < nValid;
        checkField("stall", 0, stall, expStall);
        if (expStall != row.expStall) begin
            tableErrors++;
            $display("At %0d ns the table expects stall %0d but the model gives %0d",
                     $time, row.expStall, expStall);
        end
        issue = !expStall && !row.mispr;

        seq = seqBase;
        for (int i = 0; i < `NUM_UOPS; i++) begin
            expOut[i].valid = req[i].valid && issue;
            expOut[i].sqN = seq;
            if (req[i].valid) seq = seq + 1'b1;
            expOut[i].tagSrcA = specMap[req[i].archSrcA];
            expOut[i].tagSrcB = specMap[req[i].archSrcB];
            expOut[i].tagDst = freeTag[i];
            for (int k = 0; k < i; k++) begin
                if (req[k].valid && req[k].archDst == req[i].archSrcA)
                    expOut[i].tagSrcA = freeTag[k];
                if (req[k].valid && req[k].archDst == req[i].archSrcB)
                    expOut[i].tagSrcB = freeTag[k];
            end
        end

        oldComm = commMap;
        if (row.mispr) begin
            for (int t = 0; t < `NUM_TAGS; t++) begin
                age = tagSqN[t] - row.misprSqN;
                if (used[t] && !committed[t] && $signed(age) > 0) used[t] = 0;
            end
            seqBase = row.misprSqN + 1'b1;
            recLeft = `NUM_ARCH_REGS;
            recIdx = 0;
        end else begin
            if (recLeft > 0) begin
                specMap[recIdx] = oldComm[recIdx];
                recIdx++;
                recLeft--;
            end
            if (issue) begin
                for (int i = 0; i < `NUM_UOPS; i++) begin
                    if (req[i].valid) begin
                        used[freeTag[i]] = 1;
                        committed[freeTag[i]] = 0;
                        tagSqN[freeTag[i]] = expOut[i].sqN;
                        specMap[req[i].archDst] = freeTag[i];
                    end
                end
                seqBase = seq;
            end
        end

        for (int i = 0; i < `NUM_UOPS; i++) begin
            if (com[i].valid) begin
                newest = 1;
                for (int k = i + 1; k < `NUM_UOPS; k++) begin
                    if (com[k].valid && com[k].archDst == com[i].archDst) newest = 0;
                end
                if (newest) begin
                    prevTag = oldComm[com[i].archDst];
                    used[prevTag] = 0;
                    committed[prevTag] = 0;
                    used[com[i].tagDst] = 1;
                    committed[com[i].tagDst] = 1;
                end else begin
                    used[com[i].tagDst] = 0;
                    committed[com[i].tagDst] = 0;
                end
                commMap[com[i].archDst] = com[i].tagDst;
            end
        end
    endtask

    initial begin
        clk = 0;
        rst = 1;
        mispr = 0;
        misprSqN = '0;
        for (int i = 0; i < `NUM_UOPS; i++) begin
            renameIn[i] = idleReq;
            commitIn[i] = idleCommit;
            expOut[i] = '0;
        end
        for (int t = 0; t < `NUM_TAGS; t++) begin
            used[t] = t < `NUM_ARCH_REGS;
            committed[t] = t < `NUM_ARCH_REGS;
            tagSqN[t] = '0;
        end
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            specMap[r] = r[`TAG_W-1:0];
            commMap[r] = r[`TAG_W-1:0];
        end
        seqBase = '0;
        recLeft = 0;
        recIdx = 0;
        loadTable();
        // Reset, every table cycle and a margin
        limit = 16 + 64;
        foreach (rows[r]) limit += rows[r].count;

        repeat (16) @(posedge clk);
        #2;
        rst = 0;

        foreach (rows[r]) begin
            for (int n = 0; n < rows[r].count; n++) begin
                @(posedge clk);
                #1;
                checkOutputs();
                #1;
                driveRow(rows[r]);
                #1;
                stepModel(rows[r]);
            end
        end
        @(posedge clk);
        #1;
        checkOutputs();

        $display("Errors: %0d mismatches, %0d table disagreements", mismatches, tableErrors);
        if (mismatches == 0 && tableErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- Rename.sv
`timescale 1ns/100ps
`include "rename_config.svh"

module Rename import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  RenameReq renameIn [`NUM_UOPS],
    input  CommitReq commitIn [`NUM_UOPS],
    input  logic mispr,
    input  logic [`SQN_W-1:0] misprSqN,
    output RenameResult renameOut [`NUM_UOPS],
    output logic stall
);

    logic [`TAG_W-1:0] issueTags [`NUM_UOPS];
    logic [`TAG_W:0] freeCount;
    logic [`TAG_W-1:0] commitPrevTag [`NUM_UOPS];
    logic commitNewest [`NUM_UOPS];
    logic commitValid [`NUM_UOPS];
    logic [`TAG_W-1:0] commitTagDst [`NUM_UOPS];
    logic issueEn;
    logic issueValid [`NUM_UOPS];
    logic [`SQN_W-1:0] issueSqN [`NUM_UOPS];
    logic [`SQN_W-1:0] seqBase;
    logic recovering;
    logic [`ARCH_W-1:0] recoveryIdx;
    logic recoveryLast;

    // Per-slot sequence numbers for the tag records, valid slots only
    always_comb begin
        issueSqN[0] = seqBase;
        for (int i = 1; i < `NUM_UOPS; i++) begin
            issueSqN[i] = issueSqN[i-1] + {{(`SQN_W - 1){1'b0}}, issueValid[i-1]};
        end
        for (int i = 0; i < `NUM_UOPS; i++) begin
            commitValid[i] = commitIn[i].valid;
            commitTagDst[i] = commitIn[i].tagDst;
        end
    end

    TagBuffer tagBuf (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .misprSqN(misprSqN),
        .issueValid(issueValid),
        .issueSqN(issueSqN),
        .commitValid(commitValid),
        .commitNewest(commitNewest),
        .commitPrevTag(commitPrevTag),
        .commitTagDst(commitTagDst),
        .issueTags(issueTags),
        .freeCount(freeCount)
    );

    RegAliasTable rat (
        .clk(clk),
        .rst(rst),
        .renameIn(renameIn),
        .issueEn(issueEn),
        .issueTags(issueTags),
        .seqBase(seqBase),
        .commitIn(commitIn),
        .recovering(recovering),
        .recoveryIdx(recoveryIdx),
        .renameOut(renameOut),
        .commitPrevTag(commitPrevTag),
        .commitNewest(commitNewest)
    );

    RenameControl ctrl (
        .clk(clk),
        .rst(rst),
        .renameIn(renameIn),
        .freeCount(freeCount),
        .mispr(mispr),
        .misprSqN(misprSqN),
        .recoveryLast(recoveryLast),
        .issueEn(issueEn),
        .issueValid(issueValid),
        .seqBase(seqBase),
        .recovering(recovering),
        .stall(stall)
    );

    RecoveryCounter recCnt (
        .clk(clk),
        .rst(rst),
        .start(mispr),
        .recoveryIdx(recoveryIdx),
        .recoveryLast(recoveryLast)
    );

endmodule

//--- RecoveryCounter.sv
`timescale 1ns/100ps
`include "rename_config.svh"

module RecoveryCounter (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic [`ARCH_W-1:0] recoveryIdx,
    output logic recoveryLast
);

    logic active;

    assign recoveryLast = active && recoveryIdx == `ARCH_W'(`NUM_ARCH_REGS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            recoveryIdx <= '0;
        end else if (start) begin
            active <= 1'b1;
            recoveryIdx <= '0;
        end else if (active) begin
            // Index stays on the last register once done
            if (recoveryLast) begin
                active <= 1'b0;
            end else begin
                recoveryIdx <= recoveryIdx + 1'b1;
            end
        end
    end

    // A second mispredict must wait until the map walk is over
    assert property (@(posedge clk) disable iff (rst) start |-> !active);

endmodule

//--- RenameControl.sv
`timescale 1ns/100ps
`include "rename_config.svh"

module RenameControl import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  RenameReq renameIn [`NUM_UOPS],
    input  logic [`TAG_W:0] freeCount,
    input  logic mispr,
    input  logic [`SQN_W-1:0] misprSqN,
    input  logic recoveryLast,
    output logic issueEn,
    output logic issueValid [`NUM_UOPS],
    output logic [`SQN_W-1:0] seqBase,
    output logic recovering,
    output logic stall
);

    localparam logic stRun = 1'b0;
    localparam logic stRecover = 1'b1;

    logic state;
    logic [`TAG_W:0] numValid;

    always_comb begin
        numValid = '0;
        for (int i = 0; i < `NUM_UOPS; i++) begin
            numValid = numValid + {{`TAG_W{1'b0}}, renameIn[i].valid};
        end
    end

    assign recovering = state == stRecover;
    assign stall = recovering || freeCount < numValid;
    // Requests seen with the mispredict are wrong-path
    assign issueEn = !stall && !mispr;

    always_comb begin
        for (int i = 0; i < `NUM_UOPS; i++) begin
            issueValid[i] = renameIn[i].valid && issueEn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stRun;
            seqBase <= '0;
        end else begin
            case (state)
                stRun: if (mispr) state <= stRecover;
                stRecover: if (recoveryLast) state <= stRun;
            endcase

            if (mispr) begin
                seqBase <= misprSqN + 1'b1;
            end else if (issueEn) begin
                seqBase <= seqBase + numValid[`SQN_W-1:0];
            end
        end
    end

endmodule

//--- RegAliasTable.sv
`timescale 1ns/100ps
`include "rename_config.svh"

module RegAliasTable import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  RenameReq renameIn [`NUM_UOPS],
    input  logic issueEn,
    input  logic [`TAG_W-1:0] issueTags [`NUM_UOPS],
    input  logic [`SQN_W-1:0] seqBase,
    input  CommitReq commitIn [`NUM_UOPS],
    input  logic recovering,
    input  logic [`ARCH_W-1:0] recoveryIdx,
    output RenameResult renameOut [`NUM_UOPS],
    output logic [`TAG_W-1:0] commitPrevTag [`NUM_UOPS],
    output logic commitNewest [`NUM_UOPS]
);

    logic [`TAG_W-1:0] specMap [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0] commMap [`NUM_ARCH_REGS];
    RenameResult result [`NUM_UOPS];

    always_comb begin
        logic [`SQN_W-1:0] seqNext;
        seqNext = seqBase;
        for (int i = 0; i < `NUM_UOPS; i++) begin
            result[i].valid = renameIn[i].valid && issueEn;
            result[i].sqN = seqNext;
            seqNext = seqNext + {{(`SQN_W - 1){1'b0}}, renameIn[i].valid};
            result[i].tagSrcA = specMap[renameIn[i].archSrcA];
            result[i].tagSrcB = specMap[renameIn[i].archSrcB];
            result[i].tagDst = issueTags[i];
            // Nearest earlier writer in the group wins
            for (int k = 0; k < i; k++) begin
                if (renameIn[k].valid && renameIn[k].archDst == renameIn[i].archSrcA) begin
                    result[i].tagSrcA = issueTags[k];
                end
                if (renameIn[k].valid && renameIn[k].archDst == renameIn[i].archSrcB) begin
                    result[i].tagSrcB = issueTags[k];
                end
            end
        end
    end

    // Only the last commit to a register in a group releases the old mapping
    always_comb begin
        for (int i = 0; i < `NUM_UOPS; i++) begin
            commitPrevTag[i] = commMap[commitIn[i].archDst];
            commitNewest[i] = 1'b1;
            for (int k = i + 1; k < `NUM_UOPS; k++) begin
                if (commitIn[k].valid && commitIn[k].archDst == commitIn[i].archDst) begin
                    commitNewest[i] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                specMap[r] <= r[`TAG_W-1:0];
                commMap[r] <= r[`TAG_W-1:0];
            end
            for (int i = 0; i < `NUM_UOPS; i++) begin
                renameOut[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `NUM_UOPS; i++) begin
                renameOut[i] <= result[i];
            end

            if (issueEn) begin
                for (int i = 0; i < `NUM_UOPS; i++) begin
                    if (renameIn[i].valid) begin
                        specMap[renameIn[i].archDst] <= issueTags[i];
                    end
                end
            end

            // Walk back to the committed state one register per cycle
            if (recovering) begin
                specMap[recoveryIdx] <= commMap[recoveryIdx];
            end

            for (int i = 0; i < `NUM_UOPS; i++) begin
                if (commitIn[i].valid) begin
                    commMap[commitIn[i].archDst] <= commitIn[i].tagDst;
                end
            end
        end
    end

endmodule

//--- TagBuffer.sv
`timescale 1ns/100ps
`include "rename_config.svh"

module TagBuffer import renamePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic mispr,
    input  logic [`SQN_W-1:0] misprSqN,
    input  logic issueValid [`NUM_UOPS],
    input  logic [`SQN_W-1:0] issueSqN [`NUM_UOPS],
    input  logic commitValid [`NUM_UOPS],
    input  logic commitNewest [`NUM_UOPS],
    input  logic [`TAG_W-1:0] commitPrevTag [`NUM_UOPS],
    input  logic [`TAG_W-1:0] commitTagDst [`NUM_UOPS],
    output logic [`TAG_W-1:0] issueTags [`NUM_UOPS],
    output logic [`TAG_W:0] freeCount
);

    TagBufEntry tags [`NUM_TAGS];
    logic tagFound [`NUM_UOPS];

    // Scan upwards, each free tag pushes the earlier picks one slot down,
    // so slot 0 ends with the highest free tag
    always_comb begin
        freeCount = '0;
        for (int i = 0; i < `NUM_UOPS; i++) begin
            issueTags[i] = '0;
            tagFound[i] = 1'b0;
        end
        for (int j = 0; j < `NUM_TAGS; j++) begin
            if (!tags[j].used) begin
                freeCount = freeCount + 1'b1;
                for (int i = `NUM_UOPS - 1; i > 0; i--) begin
                    issueTags[i] = issueTags[i-1];
                    tagFound[i] = tagFound[i-1];
                end
                issueTags[0] = j[`TAG_W-1:0];
                tagFound[0] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Low tags hold the initial identity mapping
            for (int j = 0; j < `NUM_TAGS; j++) begin
                tags[j].used <= j < `NUM_ARCH_REGS;
                tags[j].committed <= j < `NUM_ARCH_REGS;
            end
        end else begin
            if (mispr) begin
                // Drop every in-flight tag younger than the mispredicted op
                for (int j = 0; j < `NUM_TAGS; j++) begin
                    if (tags[j].used && !tags[j].committed &&
                        $signed(tags[j].sqN - misprSqN) > 0) begin
                        tags[j].used <= 1'b0;
                    end
                end
            end else begin
                for (int i = 0; i < `NUM_UOPS; i++) begin
                    if (issueValid[i]) begin
                        tags[issueTags[i]].used <= 1'b1;
                        tags[issueTags[i]].committed <= 1'b0;
                        tags[issueTags[i]].sqN <= issueSqN[i];
                    end
                end
            end

            for (int i = 0; i < `NUM_UOPS; i++) begin
                if (commitValid[i]) begin
                    if (commitNewest[i]) begin
                        // Replaced mapping goes back to the pool
                        tags[commitPrevTag[i]].used <= 1'b0;
                        tags[commitPrevTag[i]].committed <= 1'b0;
                        tags[commitTagDst[i]].used <= 1'b1;
                        tags[commitTagDst[i]].committed <= 1'b1;
                    end else begin
                        // Overwritten within the same commit group
                        tags[commitTagDst[i]].used <= 1'b0;
                        tags[commitTagDst[i]].committed <= 1'b0;
                    end
                end
            end
        end
    end

    // Stall logic in control must keep allocations within the free pool
    for (genvar g = 0; g < `NUM_UOPS; g++) begin : gAllocCheck
        assert property (@(posedge clk) disable iff (rst)
            issueValid[g] && !mispr |-> tagFound[g]);
    end

endmodule

//--- renamePkg.sv
`include "rename_config.svh"

package renamePkg;

    // One micro-op entering rename
    typedef struct packed {
        logic valid;
        logic [`ARCH_W-1:0] archSrcA;
        logic [`ARCH_W-1:0] archSrcB;
        logic [`ARCH_W-1:0] archDst;
    } RenameReq;

    // Renamed micro-op, one cycle after the request
    typedef struct packed {
        logic valid;
        logic [`SQN_W-1:0] sqN;
        logic [`TAG_W-1:0] tagSrcA;
        logic [`TAG_W-1:0] tagSrcB;
        logic [`TAG_W-1:0] tagDst;
    } RenameResult;

    // Retiring micro-op
    typedef struct packed {
        logic valid;
        logic [`ARCH_W-1:0] archDst;
        logic [`TAG_W-1:0] tagDst;
    } CommitReq;

    // State kept per physical tag in the free list
    typedef struct packed {
        logic used;
        logic committed;
        logic [`SQN_W-1:0] sqN;
    } TagBufEntry;

endpackage

//--- rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Rename group width
`define NUM_UOPS 2

// Register file sizes
`define NUM_ARCH_REGS 32
`define NUM_TAGS 64

// Field widths
`define TAG_W 6
`define ARCH_W 5
`define SQN_W 6

`endif
